//--- design/buf_pkg.sv
`include "buf_params.svh"

package buf_pkg;

   // One complex sample from one antenna input.
   typedef struct packed {
      logic [3:0] antenna;   // Antenna index.
      logic [9:0] i_val;     // In-phase value.
      logic [9:0] q_val;     // Quadrature value.
   } sample_t;

   // Word address into the RAM tiles.
   typedef logic [`BUF_AW-1:0] addr_t;

   // Item count, 0 to 33.
   // One bit wider than the address so RAM full (32) plus the
   // output register still fits.
   typedef logic [`BUF_AW:0] level_t;

endpackage

//--- design/ram32_wide.sv
`include "buf_params.svh"

// RAM of any width built from 6-bit tiles side by side.
module ram32_wide #(
   parameter int WIDTH = 24   // Data bits per word.
) (
   input  logic              WCLK,    // Write clock.
   input  logic              we,      // Write enable, shared by all tiles.
   input  buf_pkg::addr_t    waddr,   // Write address, shared.
   input  logic [WIDTH-1:0]  din,     // Write data.
   input  buf_pkg::addr_t    raddr,   // Read address, shared.
   output logic [WIDTH-1:0]  dout     // Read data.
);

   localparam int NT = (WIDTH + `BUF_TILE_W - 1) / `BUF_TILE_W;   // Tile count.
   localparam int PADW = NT * `BUF_TILE_W;                          // Padded width.

   logic [PADW-1:0] din_pad;    // Write word, top slice zero-filled.
   logic [PADW-1:0] dout_pad;   // Read word from all tiles.

   // Zero-pad the top slice on write.
   always_comb begin
      din_pad = '0;              // Unused top bits.
      din_pad[WIDTH-1:0] = din;  // Real payload.
   end

   // One tile per 6-bit slice.
   for (genvar t = 0; t < NT; t++) begin : g_tile
      ram32x6_sdp i_tile (
         .WCLK  (WCLK),
         .we    (we),
         .waddr (waddr),
         .din   (din_pad[t*`BUF_TILE_W +: `BUF_TILE_W]),
         .raddr (raddr),
         .dout  (dout_pad[t*`BUF_TILE_W +: `BUF_TILE_W])
      );
   end

   // Drop the padding on read.
   assign dout = dout_pad[WIDTH-1:0];   // Truncate top slice.

endmodule

//--- design/ram32x6_sdp.sv
`include "buf_params.svh"

// Simple dual-port RAM tile.
// One write port on WCLK, one asynchronous read port.
module ram32x6_sdp (
   input  logic                    WCLK,    // Write clock.
   input  logic                    we,      // Write enable.
   input  buf_pkg::addr_t          waddr,   // Write address.
   input  logic [`BUF_TILE_W-1:0]  din,     // Write data.
   input  buf_pkg::addr_t          raddr,   // Read address.
   output logic [`BUF_TILE_W-1:0]  dout     // Read data, no clock.
);

   logic [`BUF_TILE_W-1:0] mem [`BUF_DEPTH];   // Storage array.

   // Write port.
   // The new word lands at the edge where we is high.
   always_ff @(posedge WCLK) begin
      if (we) begin
         mem[waddr] <= din;   // Synchronous write.
      end
   end

   // Read port.
   // A read of the address being written returns the old word
   // until the edge has passed.
   assign dout = mem[raddr];   // Combinational read.

endmodule

//--- design/sample_buffer.sv
// Sample buffer top.
// Queues antenna samples between a source and a sink.
module sample_buffer (
   input  logic              WCLK,        // Clock for the whole path.
   input  logic              rst_n,       // Async reset, active low.
   // Input side.
   input  logic              in_valid,    // Source offers a sample.
   input  buf_pkg::sample_t  in_data,     // Sample from the antenna side.
   output logic              in_ready,    // Buffer accepts.
   // Output side.
   output logic              out_valid,   // Sample available.
   output buf_pkg::sample_t  out_data,    // Oldest sample.
   input  logic              out_ready,   // Sink accepts.
   // Status.
   output buf_pkg::level_t   level        // Samples held, 0 to 33.
);

   // One FIFO of samples.
   // Latency and capacity are those of the FIFO, no extra stages.
   sample_fifo #(
      .payload_t (buf_pkg::sample_t)
   ) i_fifo (
      .WCLK      (WCLK),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_ready (out_ready),
      .level     (level)
   );

endmodule

//--- design/sample_fifo.sv
`include "buf_params.svh"

// FIFO with distributed RAM storage and one output register.
// Holds 32 items in RAM and one more in the output stage.
module sample_fifo #(
   parameter type payload_t = logic [7:0]   // Any packed payload.
) (
   input  logic             WCLK,        // Clock.
   input  logic             rst_n,       // Asynchronous active-low reset.
   input  logic             in_valid,    // Source has an item.
   input  payload_t         in_data,     // Item from source.
   output logic             in_ready,    // Room in RAM.
   output logic             out_valid,   // Output register holds an item.
   output payload_t         out_data,    // Output register.
   input  logic             out_ready,   // Sink takes the item.
   output buf_pkg::level_t  level        // Items held in total.
);

   localparam int PW = $bits(payload_t);   // Payload width.
   localparam buf_pkg::level_t RAM_FULL = buf_pkg::level_t'(`BUF_DEPTH);

   buf_pkg::addr_t   wr_ptr;     // Next RAM word to write.
   buf_pkg::addr_t   rd_ptr;     // RAM head.
   buf_pkg::level_t  ram_cnt;    // Words held in RAM from 0 to 32.
   logic             wr_en;      // Input transfer this cycle.
   logic             rd_en;      // RAM head moves to the output register.
   logic             ram_empty;  // No word in RAM.
   logic             reg_free;   // Output register empty or being taken.
   logic [PW-1:0]    ram_wdata;  // Payload as flat bits.
   logic [PW-1:0]    ram_rdata;  // RAM head as flat bits.

   // Handshake and control.
   assign ram_empty = (ram_cnt == '0);
   assign in_ready  = (ram_cnt != RAM_FULL);       // Low only with RAM full.
   assign wr_en     = in_valid & in_ready;         // Accepting edge.
   assign reg_free  = ~out_valid | out_ready;      // Stage can take a word.
   assign rd_en     = reg_free & ~ram_empty;       // Head leaves RAM.

   assign ram_wdata = PW'(in_data);                // Flatten for the tiles.

   // Storage.
   ram32_wide #(
      .WIDTH (PW)
   ) i_ram (
      .WCLK  (WCLK),
      .we    (wr_en),
      .waddr (wr_ptr),
      .din   (ram_wdata),
      .raddr (rd_ptr),
      .dout  (ram_rdata)
   );

   // Pointers wrap at 32 by their width.
   always_ff @(posedge WCLK or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;   // Past the written word.
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;   // Past the head just read.
         end
      end
   end

   // RAM occupancy.
   always_ff @(posedge WCLK or negedge rst_n) begin
      if (!rst_n) begin
         ram_cnt <= '0;
      end else begin
         case ({wr_en, rd_en})
            2'b10:   ram_cnt <= ram_cnt + 1'b1;   // Write only.
            2'b01:   ram_cnt <= ram_cnt - 1'b1;   // Read only.
            default: ram_cnt <= ram_cnt;          // Both or neither.
         endcase
      end
   end

   // Output register valid flag.
   always_ff @(posedge WCLK or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (rd_en) begin
         out_valid <= 1'b1;        // Fresh head loaded.
      end else if (out_ready) begin
         out_valid <= 1'b0;        // Taken with nothing behind it.
      end
   end

   // Output register payload.
   always_ff @(posedge WCLK) begin
      if (rd_en) begin
         out_data <= payload_t'(ram_rdata);   // Load the RAM head.
      end
   end

   // RAM words plus the output stage.
   assign level = ram_cnt + buf_pkg::level_t'(out_valid);

   // A write never lands on the unread head.
   // Equal pointers with words held mean RAM is full.
   a_no_write_full : assert property (
      @(posedge WCLK) disable iff (!rst_n)
      wr_en |-> (ram_empty || (wr_ptr != rd_ptr))
   ) else $error("sample_fifo: write with RAM full");

   // A read never takes a word that was not written.
   a_no_read_empty : assert property (
      @(posedge WCLK) disable iff (!rst_n)
      rd_en |-> ((ram_cnt == RAM_FULL) || (wr_ptr != rd_ptr))
   ) else $error("sample_fifo: read with RAM empty");

   // Item held while the sink stalls.
   a_out_hold : assert property (
      @(posedge WCLK) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
   ) else $error("sample_fifo: output changed under back-pressure");

endmodule

//--- include/buf_params.svh
`ifndef BUF_PARAMS_SVH
`define BUF_PARAMS_SVH

// Geometry of one distributed RAM tile.
`define BUF_DEPTH   32   // Words per tile.
`define BUF_AW      5    // Address bits for BUF_DEPTH words.
`define BUF_TILE_W  6    // Data bits per tile.

`endif

//--- sim.f
+incdir+include
design/buf_pkg.sv
design/ram32x6_sdp.sv
design/ram32_wide.sv
design/sample_fifo.sv
design/sample_buffer.sv
test/tb_sample_buffer.sv

//--- test/tb_sample_buffer.sv
`include "buf_params.svh"

module tb_sample_buffer;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES  = 16;                     // Reset length.
   localparam int RANDOM_CYCLES = 4000;                   // Random traffic length.
   localparam int BUDGET_CYCLES = RESET_CYCLES + 4300;    // All tests together.
   localparam int CAPACITY      = `BUF_DEPTH + 1;         // RAM plus output register.

   logic              WCLK;
   logic              rst_n;
   logic              in_valid;
   buf_pkg::sample_t  in_data;
   logic              in_ready;
   logic              out_valid;
   buf_pkg::sample_t  out_data;
   logic              out_ready;
   buf_pkg::level_t   level;

   logic [31:0]       lfsr_state = 32'h8f64470d;   // Fixed seed.
   buf_pkg::sample_t  model_q[$];                   // Items held with the oldest first.
   int                exp_ram = 0;                  // Expected words in RAM.
   logic              exp_ov = 1'b0;                // Expected output register valid.
   int                errors = 0;
   int                tests_passed = 0;
   int                tests_failed = 0;

   sample_buffer i_dut (
      .WCLK      (WCLK),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_ready (out_ready),
      .level     (level)
   );

   initial WCLK = 1'b0;
   always #5 WCLK = ~WCLK;   // 10 ns period.

   // Fibonacci LFSR with taps 32 22 2 1, stepped once per bit.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int k = 0; k < n; k++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         val = {val[30:0], fb};   // Bit taken.
      end
      return val;
   endfunction

   function automatic buf_pkg::sample_t rand_sample();
      return buf_pkg::sample_t'(rand_bits($bits(buf_pkg::sample_t)));
   endfunction

   task automatic check_eq(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
      assert (act_v === exp_v) else begin
         $display("ERROR %0d ns %s expected %0h actual %0h", $time, name, exp_v, act_v);
         errors++;
      end
   endtask

   // One clock. Drive at the rising edge, check and predict at the falling edge.
   task automatic clock_cycle(input logic v, input buf_pkg::sample_t d, input logic r,
                              output logic acc, output logic took);
      logic rd;
      @(posedge WCLK);
      in_valid  <= v;
      in_data   <= d;
      out_ready <= r;
      @(negedge WCLK);
      check_eq("in_ready", exp_ram != `BUF_DEPTH, in_ready);   // Low only with RAM full.
      check_eq("out_valid", exp_ov, out_valid);
      check_eq("level", model_q.size(), level);
      acc  = v && (exp_ram != `BUF_DEPTH);                      // Transfers at the next edge.
      took = exp_ov && r;
      rd   = (!exp_ov || r) && (exp_ram != 0);                  // RAM head to register.
      if (took) begin
         assert (model_q.size() != 0) else begin
            $display("Output transfer seen while no item was expected");
            errors++;
         end
         if (model_q.size() != 0) begin
            check_eq("out_data", model_q[0], out_data);   // First in, first out.
            model_q.delete(0);
         end
      end
      if (acc) begin
         model_q.push_back(d);
      end
      exp_ram = exp_ram + int'(acc) - int'(rd);
      if (rd) begin
         exp_ov = 1'b1;
      end else if (r) begin
         exp_ov = 1'b0;
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      if (errors == err_start) begin
         tests_passed++;
         $display("Test %s: pass", name);
      end else begin
         tests_failed++;
         $display("Test %s: fail, %0d errors", name, errors - err_start);
      end
   endtask

   // Watchdog at twice the cycle budget.
   initial begin
      #(2 * BUDGET_CYCLES * 10);
      $display("Timeout: the run did not finish within %0d cycles", 2 * BUDGET_CYCLES);
      $display("Regression failed");
      $finish;
   end

   initial begin
      logic              v;
      logic              r;
      logic              acc;
      logic              took;
      buf_pkg::sample_t  d;
      buf_pkg::sample_t  first;
      int                n;
      int                n_acc;
      int                err0;

      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_data   = '0;
      out_ready = 1'b0;
      repeat (RESET_CYCLES) @(posedge WCLK);
      rst_n <= 1'b1;

      // Reset state.
      err0 = errors;
      @(negedge WCLK);
      check_eq("out_valid", 0, out_valid);
      check_eq("in_ready", 1, in_ready);
      check_eq("level", 0, level);
      finish_test("reset", err0);

      // One item through an empty FIFO.
      err0 = errors;
      d = rand_sample();
      clock_cycle(1'b1, d, 1'b1, acc, took);
      n = 0;
      do begin
         clock_cycle(1'b0, '0, 1'b1, acc, took);
         n++;
      end while (!out_valid && n < 8);
      check_eq("latency edges", 2, n);   // Edge N+1 after the accepting edge N.
      check_eq("out_data", d, out_data);
      clock_cycle(1'b0, '0, 1'b1, acc, took);
      check_eq("level", 0, level);
      finish_test("latency", err0);

      // Fill with the sink stalled.
      err0 = errors;
      n_acc = 0;
      acc = 1'b1;
      first = '0;
      for (int k = 0; k < CAPACITY + 7; k++) begin
         if (acc) begin
            d = rand_sample();   // New item only after the last was taken.
         end
         clock_cycle(1'b1, d, 1'b0, acc, took);
         if (in_ready) begin   // DUT takes the offered item at the next edge.
            if (n_acc == 0) begin
               first = d;
            end
            n_acc++;
         end
         if (out_valid) begin
            check_eq("out_data", first, out_data);   // Head held under back-pressure.
         end
      end
      check_eq("acceptances", CAPACITY, n_acc);
      check_eq("level", CAPACITY, level);
      check_eq("in_ready", 0, in_ready);
      finish_test("fill", err0);

      // Random traffic. The pending item from the fill is kept.
      err0 = errors;
      v = 1'b1;
      for (int k = 0; k < RANDOM_CYCLES; k++) begin
         if (!(v && !acc)) begin
            v = (rand_bits(1) != '0);
            d = rand_sample();
         end
         r = (rand_bits(1) != '0);
         clock_cycle(v, d, r, acc, took);
      end
      finish_test("random", err0);

      // Drain with the input stopped.
      err0 = errors;
      n = 0;
      while ((model_q.size() != 0 || (v && !acc)) && n < 100) begin
         if (!(v && !acc)) begin
            v = 1'b0;   // Stop once nothing is pending.
         end
         clock_cycle(v, d, 1'b1, acc, took);
         n++;
      end
      assert (n < 100) else begin
         $display("Drain did not empty the buffer within 100 cycles");
         errors++;
      end
      clock_cycle(1'b0, '0, 1'b1, acc, took);
      check_eq("out_valid", 0, out_valid);
      check_eq("level", 0, level);
      check_eq("in_ready", 1, in_ready);
      finish_test("drain", err0);

      $display("Tests passed %0d, tests failed %0d, errors %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
